//--- hw/rv_pkg.sv
/*
 * rv32 core shared definitions
 * opcodes, ALU function codes, register write sources and the instruction union
 */
package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] alu_src_t;
  typedef logic [1:0] wr_src_t;

  localparam int BYTE_NUM = 4;

  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_REG    = 7'b0110011;

  // ALU function codes follow funct3
  localparam alu_src_t ALU_ADD  = 3'b000;
  localparam alu_src_t ALU_SLL  = 3'b001;
  localparam alu_src_t ALU_SLT  = 3'b010;
  localparam alu_src_t ALU_SLTU = 3'b011;
  localparam alu_src_t ALU_XOR  = 3'b100;
  localparam alu_src_t ALU_SR   = 3'b101;
  localparam alu_src_t ALU_OR   = 3'b110;
  localparam alu_src_t ALU_AND  = 3'b111;

  localparam wr_src_t WR_ALU = 2'b00;
  localparam wr_src_t WR_MEM = 2'b10;
  localparam wr_src_t WR_PC4 = 2'b11;

  // all six formats overlay the same instruction word
  typedef union packed {
    struct packed {
      logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
      logic [2:0] funct3; logic [4:0] rd; opcode_t opcode;
    } r;
    struct packed {
      logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3;
      logic [4:0] rd; opcode_t opcode;
    } i;
    struct packed {
      logic [6:0] imm_hi; logic [4:0] rs2; logic [4:0] rs1;
      logic [2:0] funct3; logic [4:0] imm_lo; opcode_t opcode;
    } s;
    struct packed {
      logic imm_12; logic [5:0] imm_10_5; logic [4:0] rs2; logic [4:0] rs1;
      logic [2:0] funct3; logic [3:0] imm_4_1; logic imm_11; opcode_t opcode;
    } b;
    struct packed {
      logic [19:0] imm_31_12; logic [4:0] rd; opcode_t opcode;
    } u;
    struct packed {
      logic imm_20; logic [9:0] imm_10_1; logic imm_11; logic [7:0] imm_19_12;
      logic [4:0] rd; opcode_t opcode;
    } j;
  } instr_u;

endpackage

//--- hw/alu.sv
/*
 * rv32 ALU
 * one shared adder/subtractor supplies add, sub, the set-less-than results
 * and the zero, negative, carry and overflow flags used by branches
 */
`timescale 1ns/100ps

module alu (
  input  rv_pkg::word_t    a,
  input  rv_pkg::word_t    b,
  input  rv_pkg::alu_src_t alu_src,
  input  logic             sub,
  input  logic             arithmetic,
  output rv_pkg::word_t    y,
  output logic             zero,
  output logic             negative,
  output logic             carry_out,
  output logic             overflow
);
  import rv_pkg::*;

  logic       do_sub;
  word_t      b_op;
  word_t      sum;
  logic [4:0] shamt;

  // the compares need a - b even when sub is low
  assign do_sub = sub | (alu_src == ALU_SLT) | (alu_src == ALU_SLTU);
  assign b_op   = b ^ {32{do_sub}};
  assign {carry_out, sum} = {1'b0, a} + {1'b0, b_op} + {32'b0, do_sub};

  assign zero     = (sum == '0);
  assign negative = sum[31];
  assign overflow = (a[31] == b_op[31]) && (sum[31] != a[31]);
  assign shamt    = b[4:0];

  always_comb begin
    case (alu_src)
      ALU_ADD:  y = sum;
      ALU_SLL:  y = a << shamt;
      ALU_SLT:  y = {31'b0, negative ^ overflow};
      ALU_SLTU: y = {31'b0, ~carry_out};
      ALU_XOR:  y = a ^ b;
      ALU_SR:   y = arithmetic ? word_t'($signed(a) >>> shamt) : a >> shamt;
      ALU_OR:   y = a | b;
      default:  y = a & b;
    endcase
  end

endmodule

//--- hw/register_file.sv
/*
 * 32 x 32 integer register file
 * two combinational read ports, one write port, x0 reads as zero
 */
`timescale 1ns/100ps

module register_file (
  input  logic          clock,
  input  logic          reset,
  input  logic [4:0]    rs1,
  input  logic [4:0]    rs2,
  input  logic [4:0]    rd,
  input  logic          wr_en,
  input  rv_pkg::word_t wr_data,
  output rv_pkg::word_t rd1,
  output rv_pkg::word_t rd2
);
  import rv_pkg::*;

  word_t regs [32];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      for (int n = 0; n < 32; n++) begin
        regs[n] <= '0;
      end
    end else if (wr_en && rd != 5'd0) begin
      regs[rd] <= wr_data;
    end
  end

  assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- hw/imm_gen.sv
/*
 * immediate generator
 * picks the format from the opcode and builds the sign-extended immediate
 */
`timescale 1ns/100ps

module imm_gen (
  input  rv_pkg::instr_u instr,
  output rv_pkg::word_t  imm
);
  import rv_pkg::*;

  always_comb begin
    case (instr.r.opcode)
      OP_IMM, OP_LOAD, OP_JALR: begin
        imm = {{20{instr.i.imm[11]}}, instr.i.imm};
      end
      OP_STORE: begin
        imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
      end
      OP_BRANCH: begin
        imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
               instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
      end
      OP_LUI, OP_AUIPC: begin
        imm = {instr.u.imm_31_12, 12'b0};
      end
      OP_JAL: begin
        imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
               instr.j.imm_11, instr.j.imm_10_1, 1'b0};
      end
      // register-register has no immediate
      default: imm = '0;
    endcase
  end

endmodule

//--- hw/datapath.sv
/*
 * rv32 multicycle datapath
 * PC, instruction and store data registers, operand selection, load
 * extension and register write-back around the ALU and register file
 */
`timescale 1ns/100ps

module datapath #(
  parameter rv_pkg::word_t RESET_PC = 32'h0
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             alua_src,
  input  logic             alub_src,
  input  rv_pkg::alu_src_t alu_src,
  input  logic             sub,
  input  logic             arithmetic,
  input  logic             alupc_src,
  input  logic             pc_src,
  input  logic             pc_en,
  input  rv_pkg::wr_src_t  wr_reg_src,
  input  logic             wr_reg_en,
  input  logic             ir_en,
  input  logic             mem_addr_src,
  output rv_pkg::opcode_t  opcode,
  output logic [2:0]       funct3,
  output logic [6:0]       funct7,
  output logic             zero,
  output logic             negative,
  output logic             carry_out,
  output logic             overflow,
  output rv_pkg::word_t    mem_addr,
  output rv_pkg::word_t    mem_wdata,
  input  rv_pkg::word_t    mem_rdata
);
  import rv_pkg::*;

  word_t      pc;
  word_t      pc_plus4;
  word_t      pc_target;
  instr_u     ir;
  word_t      wdata_q;
  word_t      imm;
  word_t      rd1;
  word_t      rd2;
  word_t      alu_a;
  word_t      alu_b;
  word_t      alu_y;
  word_t      load_data;
  word_t      wr_data;
  logic [4:0] rs1_addr;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      pc <= RESET_PC;
    end else if (pc_en) begin
      pc <= pc_src ? pc_target : pc_plus4;
    end
  end

  always_ff @(posedge clock) begin
    if (ir_en) begin
      ir <= mem_rdata;
    end
    // store data follows rs2, stable once decode is done
    wdata_q <= rd2;
  end

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = alupc_src ? {alu_y[31:1], 1'b0} : pc + imm;

  assign opcode = ir.r.opcode;
  assign funct3 = ir.r.funct3;
  assign funct7 = ir.r.funct7;

  // lui adds its immediate to x0, its rs1 bits belong to the immediate
  assign rs1_addr = (ir.r.opcode == OP_LUI) ? 5'd0 : ir.r.rs1;

  register_file regs0 (
    .clock(clock), .reset(reset), .rs1(rs1_addr), .rs2(ir.r.rs2), .rd(ir.r.rd),
    .wr_en(wr_reg_en), .wr_data(wr_data), .rd1(rd1), .rd2(rd2)
  );

  imm_gen imm0 (.instr(ir), .imm(imm));

  assign alu_a = alua_src ? pc : rd1;
  assign alu_b = alub_src ? imm : rd2;

  alu alu0 (
    .a(alu_a), .b(alu_b), .alu_src(alu_src), .sub(sub), .arithmetic(arithmetic),
    .y(alu_y), .zero(zero), .negative(negative), .carry_out(carry_out),
    .overflow(overflow)
  );

  // load data arrives in the low lanes
  always_comb begin
    case (ir.r.funct3)
      3'b000:  load_data = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
      3'b001:  load_data = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
      3'b100:  load_data = {24'b0, mem_rdata[7:0]};
      3'b101:  load_data = {16'b0, mem_rdata[15:0]};
      default: load_data = mem_rdata;
    endcase
  end

  always_comb begin
    case (wr_reg_src)
      WR_MEM:  wr_data = load_data;
      WR_PC4:  wr_data = pc_plus4;
      default: wr_data = alu_y;
    endcase
  end

  assign mem_addr  = mem_addr_src ? alu_y : pc;
  assign mem_wdata = wdata_q;

endmodule

//--- hw/control_unit.sv
/*
 * multicycle control unit
 * steps each instruction through fetch, decode and execute or load/store,
 * driving the datapath selects and the memory strobes
 */
`timescale 1ns/100ps

module control_unit (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       mem_busy,
  output logic                       mem_rd_en,
  output logic                       mem_wr_en,
  output logic [rv_pkg::BYTE_NUM-1:0] mem_byte_en,
  input  rv_pkg::opcode_t            opcode,
  input  logic [2:0]                 funct3,
  input  logic [6:0]                 funct7,
  input  logic                       zero,
  input  logic                       negative,
  input  logic                       carry_out,
  input  logic                       overflow,
  output logic                       alua_src,
  output logic                       alub_src,
  output rv_pkg::alu_src_t           alu_src,
  output logic                       sub,
  output logic                       arithmetic,
  output logic                       alupc_src,
  output logic                       pc_src,
  output logic                       pc_en,
  output rv_pkg::wr_src_t            wr_reg_src,
  output logic                       wr_reg_en,
  output logic                       ir_en,
  output logic                       mem_addr_src,
  output logic                       halted
);
  import rv_pkg::*;

  localparam logic [3:0] IDLE    = 4'h0;
  localparam logic [3:0] FETCH   = 4'h1;
  localparam logic [3:0] FETCH2  = 4'h2;
  localparam logic [3:0] DECODE  = 4'h3;
  localparam logic [3:0] REG_REG = 4'h4;
  localparam logic [3:0] LUI     = 4'h5;
  localparam logic [3:0] REG_IMM = 4'h6;
  localparam logic [3:0] AUIPC   = 4'h7;
  localparam logic [3:0] JAL     = 4'h8;
  localparam logic [3:0] BRANCH  = 4'h9;
  localparam logic [3:0] JALR    = 4'hA;
  localparam logic [3:0] LOAD    = 4'hB;
  localparam logic [3:0] LOAD2   = 4'hC;
  localparam logic [3:0] STORE   = 4'hD;
  localparam logic [3:0] STORE2  = 4'hE;
  localparam logic [3:0] HALT    = 4'hF;

  logic [3:0] state;
  logic [3:0] next_state;
  logic       eq_cond;
  logic       lt_cond;
  logic       ltu_cond;
  logic       take_branch;
  logic [BYTE_NUM-1:0] size_en;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // branch decision from the subtract flags, funct3[0] inverts the sense
  assign eq_cond     = zero ^ funct3[0];
  assign lt_cond     = (negative ^ overflow) ^ funct3[0];
  assign ltu_cond    = ~carry_out ^ funct3[0];
  assign take_branch = funct3[1] ? ltu_cond : (funct3[2] ? lt_cond : eq_cond);

  always_comb begin
    case (funct3[1:0])
      2'b00:   size_en = 4'h1;
      2'b01:   size_en = 4'h3;
      default: size_en = 4'hF;
    endcase
  end

  assign halted = (state == HALT);

  always_comb begin
    next_state   = state;
    mem_rd_en    = 1'b0;
    mem_wr_en    = 1'b0;
    mem_byte_en  = '0;
    alua_src     = 1'b0;
    alub_src     = 1'b0;
    alu_src      = ALU_ADD;
    sub          = 1'b0;
    arithmetic   = 1'b0;
    alupc_src    = 1'b0;
    pc_src       = 1'b0;
    pc_en        = 1'b0;
    wr_reg_src   = WR_ALU;
    wr_reg_en    = 1'b0;
    ir_en        = 1'b0;
    mem_addr_src = 1'b0;

    case (state)
      IDLE: next_state = FETCH;
      FETCH: begin
        mem_rd_en   = 1'b1;
        mem_byte_en = '1;
        if (mem_busy) begin
          next_state = FETCH2;
        end
      end
      FETCH2: begin
        mem_byte_en = '1;
        if (mem_busy) begin
          mem_rd_en = 1'b1;
        end else begin
          ir_en      = 1'b1;
          next_state = DECODE;
        end
      end
      DECODE: begin
        case (opcode)
          OP_REG:    next_state = REG_REG;
          OP_IMM:    next_state = REG_IMM;
          OP_LUI:    next_state = LUI;
          OP_AUIPC:  next_state = AUIPC;
          OP_JAL:    next_state = JAL;
          OP_JALR:   next_state = JALR;
          OP_BRANCH: next_state = BRANCH;
          OP_LOAD:   next_state = LOAD;
          OP_STORE:  next_state = STORE;
          default:   next_state = HALT;
        endcase
      end
      REG_REG: begin
        alu_src    = funct3;
        sub        = funct7[5];
        arithmetic = funct7[5];
        wr_reg_en  = 1'b1;
        pc_en      = 1'b1;
        next_state = FETCH;
      end
      REG_IMM: begin
        alub_src   = 1'b1;
        alu_src    = funct3;
        // only srai carries funct7 in its immediate
        arithmetic = (funct3 == ALU_SR) & funct7[5];
        wr_reg_en  = 1'b1;
        pc_en      = 1'b1;
        next_state = FETCH;
      end
      LUI: begin
        alub_src   = 1'b1;
        wr_reg_en  = 1'b1;
        pc_en      = 1'b1;
        next_state = FETCH;
      end
      AUIPC: begin
        alua_src   = 1'b1;
        alub_src   = 1'b1;
        wr_reg_en  = 1'b1;
        pc_en      = 1'b1;
        next_state = FETCH;
      end
      JAL: begin
        pc_src     = 1'b1;
        wr_reg_src = WR_PC4;
        wr_reg_en  = 1'b1;
        pc_en      = 1'b1;
        next_state = FETCH;
      end
      JALR: begin
        alub_src   = 1'b1;
        alupc_src  = 1'b1;
        pc_src     = 1'b1;
        wr_reg_src = WR_PC4;
        wr_reg_en  = 1'b1;
        pc_en      = 1'b1;
        next_state = FETCH;
      end
      BRANCH: begin
        sub        = 1'b1;
        pc_src     = take_branch;
        pc_en      = 1'b1;
        next_state = FETCH;
      end
      LOAD, LOAD2: begin
        alub_src     = 1'b1;
        mem_addr_src = 1'b1;
        mem_byte_en  = size_en;
        wr_reg_src   = WR_MEM;
        if (state == LOAD) begin
          mem_rd_en = 1'b1;
          if (mem_busy) begin
            next_state = LOAD2;
          end
        end else if (mem_busy) begin
          mem_rd_en = 1'b1;
        end else begin
          wr_reg_en  = 1'b1;
          pc_en      = 1'b1;
          next_state = FETCH;
        end
      end
      STORE, STORE2: begin
        alub_src     = 1'b1;
        mem_addr_src = 1'b1;
        mem_byte_en  = size_en;
        if (state == STORE) begin
          mem_wr_en = 1'b1;
          if (mem_busy) begin
            next_state = STORE2;
          end
        end else if (mem_busy) begin
          mem_wr_en = 1'b1;
        end else begin
          pc_en      = 1'b1;
          next_state = FETCH;
        end
      end
      default: next_state = HALT;
    endcase
  end

endmodule

//--- hw/rv32_multicycle.sv
/*
 * rv32 multicycle core top level
 * joins the control unit and the datapath to the shared memory port
 */
`timescale 1ns/100ps

module rv32_multicycle #(
  parameter rv_pkg::word_t RESET_PC = 32'h0
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        mem_busy,
  input  rv_pkg::word_t               mem_rdata,
  output rv_pkg::word_t               mem_addr,
  output rv_pkg::word_t               mem_wdata,
  output logic                        mem_rd_en,
  output logic                        mem_wr_en,
  output logic [rv_pkg::BYTE_NUM-1:0] mem_byte_en,
  output logic                        halted
);
  import rv_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       zero, negative, carry_out, overflow;
  logic       alua_src, alub_src, sub, arithmetic;
  alu_src_t   alu_src;
  logic       alupc_src, pc_src, pc_en;
  wr_src_t    wr_reg_src;
  logic       wr_reg_en, ir_en, mem_addr_src;

  control_unit ctrl0 (
    .clock(clock), .reset(reset), .mem_busy(mem_busy), .mem_rd_en(mem_rd_en),
    .mem_wr_en(mem_wr_en), .mem_byte_en(mem_byte_en), .opcode(opcode),
    .funct3(funct3), .funct7(funct7), .zero(zero), .negative(negative),
    .carry_out(carry_out), .overflow(overflow), .alua_src(alua_src),
    .alub_src(alub_src), .alu_src(alu_src), .sub(sub), .arithmetic(arithmetic),
    .alupc_src(alupc_src), .pc_src(pc_src), .pc_en(pc_en), .wr_reg_src(wr_reg_src),
    .wr_reg_en(wr_reg_en), .ir_en(ir_en), .mem_addr_src(mem_addr_src),
    .halted(halted)
  );

  datapath #(.RESET_PC(RESET_PC)) dp0 (
    .clock(clock), .reset(reset), .alua_src(alua_src), .alub_src(alub_src),
    .alu_src(alu_src), .sub(sub), .arithmetic(arithmetic), .alupc_src(alupc_src),
    .pc_src(pc_src), .pc_en(pc_en), .wr_reg_src(wr_reg_src), .wr_reg_en(wr_reg_en),
    .ir_en(ir_en), .mem_addr_src(mem_addr_src), .opcode(opcode), .funct3(funct3),
    .funct7(funct7), .zero(zero), .negative(negative), .carry_out(carry_out),
    .overflow(overflow), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_rdata(mem_rdata)
  );

endmodule

//--- verif/tb_memory.sv
/*
 * testbench memory model
 * byte-addressed storage behind the core's strobe/busy port, with random
 * busy latency and direct word access for program loading and result checks
 */
`timescale 1ns/100ps

module tb_memory #(
  parameter int MEM_BYTES = 4096
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        rd_en,
  input  logic                        wr_en,
  input  logic [rv_pkg::BYTE_NUM-1:0] byte_en,
  input  rv_pkg::word_t               addr,
  input  rv_pkg::word_t               wdata,
  output logic                        busy,
  output rv_pkg::word_t               rdata
);
  import rv_pkg::*;

  localparam logic [1:0] IDLE = 2'd0;
  localparam logic [1:0] WAIT = 2'd1;
  localparam logic [1:0] BUSY = 2'd2;

  logic [7:0]          mem [MEM_BYTES];
  logic [1:0]          phase;
  int unsigned         count;
  word_t               req_addr;
  word_t               req_wdata;
  word_t               read_data;
  logic [BYTE_NUM-1:0] req_en;
  logic                req_write;

  initial begin
    busy  = 1'b0;
    rdata = '0;
    phase = IDLE;
  end

  function automatic int byte_index(input word_t a);
    return int'(a & word_t'(MEM_BYTES - 1));
  endfunction

  // every byte gets a value built from all of its address bits
  task automatic fill();
    for (int a = 0; a < MEM_BYTES; a++) begin
      mem[a] = 8'(a ^ (a >> 8)) ^ 8'ha5;
    end
  endtask

  task automatic write_word(input word_t a, input word_t data);
    for (int k = 0; k < BYTE_NUM; k++) begin
      mem[byte_index(a + k)] = data[8*k +: 8];
    end
  endtask

  function automatic word_t read_word(input word_t a);
    word_t data;
    for (int k = 0; k < BYTE_NUM; k++) begin
      data[8*k +: 8] = mem[byte_index(a + k)];
    end
    return data;
  endfunction

  always @(negedge clock) begin
    if (reset) begin
      busy  <= 1'b0;
      phase = IDLE;
    end else begin
      case (phase)
        IDLE: begin
          if (rd_en || wr_en) begin
            req_addr  = addr;
            req_wdata = wdata;
            req_en    = byte_en;
            req_write = wr_en;
            count     = $urandom % 4 + 1;
            phase     = WAIT;
          end
        end
        WAIT: begin
          count--;
          if (count == 0) begin
            busy  <= 1'b1;
            count = $urandom % 3 + 1;
            phase = BUSY;
          end
        end
        default: begin
          count--;
          if (count == 0) begin
            busy  <= 1'b0;
            phase = IDLE;
            // enabled lanes map onto consecutive bytes from the request address
            read_data = '0;
            for (int k = 0; k < BYTE_NUM; k++) begin
              if (req_en[k] && req_write) begin
                mem[byte_index(req_addr + k)] = req_wdata[8*k +: 8];
              end else if (req_en[k]) begin
                read_data[8*k +: 8] = mem[byte_index(req_addr + k)];
              end
            end
            if (!req_write) begin
              rdata <= read_data;
            end
          end
        end
      endcase
    end
  end

endmodule

//--- verif/tb_rv32.sv
/*
 * rv32 multicycle core testbench
 * builds small programs in the memory model, runs the core until it halts
 * and checks the stored results against the RISC-V rules
 */
`timescale 1ns/100ps

module tb_rv32;
  import rv_pkg::*;

  localparam word_t DATA_BASE = 32'h400;
  localparam word_t ECALL     = 32'h0000_0073;

  logic                clock = 1'b0;
  logic                reset;
  logic                mem_busy;
  word_t               mem_rdata;
  word_t               mem_addr;
  word_t               mem_wdata;
  logic                mem_rd_en;
  logic                mem_wr_en;
  logic [BYTE_NUM-1:0] mem_byte_en;
  logic                halted;

  word_t       prog_pc;
  int          slot;
  word_t       exp_addr [$];
  word_t       exp_data [$];

  always #20 clock = ~clock;

  rv32_multicycle #(.RESET_PC(32'h0)) dut0 (
    .clock(clock), .reset(reset), .mem_busy(mem_busy), .mem_rdata(mem_rdata),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rd_en(mem_rd_en),
    .mem_wr_en(mem_wr_en), .mem_byte_en(mem_byte_en), .halted(halted)
  );

  tb_memory mem0 (
    .clock(clock), .reset(reset), .rd_en(mem_rd_en), .wr_en(mem_wr_en),
    .byte_en(mem_byte_en), .addr(mem_addr), .wdata(mem_wdata), .busy(mem_busy),
    .rdata(mem_rdata)
  );

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
      $display("Test failures found");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic check_halt(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      $display("Test failures found");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // instruction encoders for each RISC-V format
  function automatic word_t r_type(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                   input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                   input logic [2:0] f3, input logic [4:0] rd,
                                   input opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                   input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
  endfunction

  function automatic word_t b_type(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                   input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic word_t u_type(input logic [19:0] imm, input logic [4:0] rd,
                                   input opcode_t op);
    return {imm, rd, op};
  endfunction

  function automatic word_t j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input word_t x, input word_t y);
    case (f3)
      3'b000:  return x == y;
      3'b001:  return x != y;
      3'b100:  return $signed(x) < $signed(y);
      3'b101:  return $signed(x) >= $signed(y);
      3'b110:  return x < y;
      default: return x >= y;
    endcase
  endfunction

  // logical shift with the vacated upper bits filled from the sign bit
  function automatic word_t shift_right_arith(input word_t x, input logic [4:0] s);
    word_t fill;
    fill = x[31] ? ~(32'hffff_ffff >> s) : 32'h0;
    return (x >> s) | fill;
  endfunction

  task automatic emit(input word_t instr);
    mem0.write_word(prog_pc, instr);
    prog_pc += 4;
  endtask

  // lui plus addi with the upper part rounded for the sign of the low twelve bits
  task automatic load_const(input logic [4:0] rd, input word_t value);
    word_t upper;
    upper = value + 32'h800;
    emit(u_type(upper[31:12], rd, OP_LUI));
    emit(i_type(value[11:0], rd, 3'b000, rd, OP_IMM));
  endtask

  task automatic expect_mem(input word_t addr, input word_t value);
    exp_addr.push_back(addr);
    exp_data.push_back(value);
  endtask

  task automatic store_expect(input logic [4:0] rs, input word_t value);
    emit(s_type(12'(slot * 4), rs, 5'd1, 3'b010));
    expect_mem(DATA_BASE + slot * 4, value);
    slot++;
  endtask

  task automatic alu_rr(input logic [6:0] f7, input logic [2:0] f3, input word_t value);
    emit(r_type(f7, 5'd3, 5'd2, f3, 5'd4));
    store_expect(5'd4, value);
  endtask

  task automatic alu_ri(input logic [11:0] imm, input logic [2:0] f3, input word_t value);
    emit(i_type(imm, 5'd2, f3, 5'd4, OP_IMM));
    store_expect(5'd4, value);
  endtask

  // x1 holds the data base in every program
  task automatic start_program();
    @(negedge clock);
    reset   = 1'b1;
    prog_pc = '0;
    slot    = 0;
    exp_addr.delete();
    exp_data.delete();
    emit(i_type(DATA_BASE[11:0], 5'd0, 3'b000, 5'd1, OP_IMM));
  endtask

  task automatic run_program();
    int limit;
    int cycles;
    emit(ECALL);
    limit = int'(prog_pc >> 2) * 20;
    repeat (10) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    check_halt("halted after reset", halted, 1'b0);
    cycles = 0;
    while (!halted && cycles < limit) begin
      @(negedge clock);
      cycles++;
    end
    if (!halted) begin
      $display("core did not halt before the cycle limit of %0d cycles", limit);
      $display("Test failures found");
      $fatal(1, "run stopped by timeout");
    end
  endtask

  task automatic check_stores();
    for (int k = 0; k < exp_addr.size(); k++) begin
      check_word($sformatf("mem[0x%h]", exp_addr[k]), mem0.read_word(exp_addr[k]),
                 exp_data[k]);
    end
  endtask

  task automatic alu_results();
    word_t       a;
    word_t       b;
    word_t       simm;
    logic [11:0] imm;
    logic [4:0]  shamt;
    start_program();
    for (int r = 0; r < 2; r++) begin
      a = $urandom;
      b = $urandom;
      if (r == 1) begin
        a[31] = 1'b1;
      end
      imm   = 12'($urandom);
      shamt = 5'($urandom);
      simm  = {{20{imm[11]}}, imm};
      load_const(5'd2, a);
      load_const(5'd3, b);
      alu_rr(7'h00, 3'b000, a + b);
      alu_rr(7'h20, 3'b000, a - b);
      alu_rr(7'h00, 3'b001, a << b[4:0]);
      alu_rr(7'h00, 3'b010, word_t'($signed(a) < $signed(b)));
      alu_rr(7'h00, 3'b011, word_t'(a < b));
      alu_rr(7'h00, 3'b100, a ^ b);
      alu_rr(7'h00, 3'b101, a >> b[4:0]);
      alu_rr(7'h20, 3'b101, shift_right_arith(a, b[4:0]));
      alu_rr(7'h00, 3'b110, a | b);
      alu_rr(7'h00, 3'b111, a & b);
      alu_ri(imm, 3'b000, a + simm);
      alu_ri(imm, 3'b010, word_t'($signed(a) < $signed(simm)));
      alu_ri(imm, 3'b011, word_t'(a < simm));
      alu_ri(imm, 3'b100, a ^ simm);
      alu_ri(imm, 3'b110, a | simm);
      alu_ri(imm, 3'b111, a & simm);
      alu_ri({7'h00, shamt}, 3'b001, a << shamt);
      alu_ri({7'h00, shamt}, 3'b101, a >> shamt);
      alu_ri({7'h20, shamt}, 3'b101, shift_right_arith(a, shamt));
    end
    run_program();
    check_stores();
  endtask

  task automatic upper_immediates();
    logic [19:0] u;
    word_t       pc;
    start_program();
    for (int r = 0; r < 2; r++) begin
      u = 20'($urandom);
      emit(u_type(u, 5'd5, OP_LUI));
      store_expect(5'd5, {u, 12'b0});
      u  = 20'($urandom);
      pc = prog_pc;
      emit(u_type(u, 5'd6, OP_AUIPC));
      store_expect(5'd6, pc + {u, 12'b0});
    end
    run_program();
    check_stores();
  endtask

  task automatic branch_paths();
    word_t      a;
    word_t      b;
    word_t      x;
    word_t      y;
    logic [2:0] f3;
    int         id;
    // a negative and b positive so that signed and unsigned compares disagree
    a  = $urandom | 32'h8000_0000;
    b  = $urandom & 32'h7fff_ffff;
    id = 0;
    start_program();
    for (int p = 0; p < 3; p++) begin
      x = (p == 2) ? b : a;
      y = (p == 0) ? a : ((p == 1) ? b : a);
      load_const(5'd2, x);
      load_const(5'd3, y);
      for (int n = 0; n < 6; n++) begin
        f3 = (n < 2) ? 3'(n) : 3'(n + 2);
        // taken path sits at +12 and the fall-through path jumps over it
        emit(b_type(13'd12, 5'd3, 5'd2, f3));
        emit(i_type(12'(32'h100 + id), 5'd0, 3'b000, 5'd7, OP_IMM));
        emit(j_type(21'd8, 5'd0));
        emit(i_type(12'(32'h200 + id), 5'd0, 3'b000, 5'd7, OP_IMM));
        store_expect(5'd7, branch_taken(f3, x, y) ? 32'h200 + id : 32'h100 + id);
        id++;
      end
    end
    run_program();
    check_stores();
  endtask

  task automatic jump_links();
    word_t pc_jal;
    word_t pc_auipc;
    start_program();
    emit(i_type(12'h0bd, 5'd0, 3'b000, 5'd9, OP_IMM));
    expect_mem(DATA_BASE, mem0.read_word(DATA_BASE));
    expect_mem(DATA_BASE + 8, mem0.read_word(DATA_BASE + 8));
    expect_mem(DATA_BASE + 12, mem0.read_word(DATA_BASE + 12));
    pc_jal = prog_pc;
    emit(j_type(21'd8, 5'd10));
    emit(s_type(12'd0, 5'd9, 5'd1, 3'b010));
    emit(s_type(12'd4, 5'd10, 5'd1, 3'b010));
    pc_auipc = prog_pc;
    emit(u_type(20'd0, 5'd11, OP_AUIPC));
    // odd offset whose target drops bit 0
    emit(i_type(12'd17, 5'd11, 3'b000, 5'd12, OP_JALR));
    emit(s_type(12'd8, 5'd9, 5'd1, 3'b010));
    emit(s_type(12'd12, 5'd9, 5'd1, 3'b010));
    emit(s_type(12'd16, 5'd12, 5'd1, 3'b010));
    expect_mem(DATA_BASE + 4, pc_jal + 4);
    expect_mem(DATA_BASE + 16, pc_auipc + 8);
    run_program();
    check_stores();
  endtask

  task automatic load_store_lanes();
    word_t w;
    word_t old8;
    word_t old12;
    int    off;
    start_program();
    for (int r = 0; r < 2; r++) begin
      w     = $urandom;
      w     = (r == 0) ? (w | 32'h8080_8080) : (w & 32'h7f7f_7f7f);
      off   = 64 * r;
      old8  = mem0.read_word(DATA_BASE + off + 8);
      old12 = mem0.read_word(DATA_BASE + off + 12);
      load_const(5'd2, w);
      emit(s_type(12'(off), 5'd2, 5'd1, 3'b010));
      emit(s_type(12'(off + 9), 5'd2, 5'd1, 3'b000));
      emit(s_type(12'(off + 14), 5'd2, 5'd1, 3'b001));
      emit(i_type(12'(off + 1), 5'd1, 3'b000, 5'd3, OP_LOAD));
      emit(i_type(12'(off + 3), 5'd1, 3'b100, 5'd4, OP_LOAD));
      emit(i_type(12'(off + 2), 5'd1, 3'b001, 5'd5, OP_LOAD));
      emit(i_type(12'(off), 5'd1, 3'b101, 5'd6, OP_LOAD));
      emit(i_type(12'(off), 5'd1, 3'b010, 5'd7, OP_LOAD));
      emit(i_type(12'(off + 9), 5'd1, 3'b000, 5'd8, OP_LOAD));
      expect_mem(DATA_BASE + off, w);
      expect_mem(DATA_BASE + off + 8, {old8[31:16], w[7:0], old8[7:0]});
      expect_mem(DATA_BASE + off + 12, {w[15:0], old12[15:0]});
      slot = off / 4 + 4;
      store_expect(5'd3, {{24{w[15]}}, w[15:8]});
      store_expect(5'd4, {24'b0, w[31:24]});
      store_expect(5'd5, {{16{w[31]}}, w[31:16]});
      store_expect(5'd6, {16'b0, w[15:0]});
      store_expect(5'd7, w);
      store_expect(5'd8, {{24{w[7]}}, w[7:0]});
    end
    run_program();
    check_stores();
  endtask

  task automatic illegal_opcode_halt();
    word_t bad;
    start_program();
    emit(i_type(12'h05a, 5'd0, 3'b000, 5'd2, OP_IMM));
    slot = 1;
    store_expect(5'd2, 32'h5a);
    bad      = $urandom;
    bad[1:0] = 2'b00;
    emit(bad);
    expect_mem(DATA_BASE, mem0.read_word(DATA_BASE));
    emit(s_type(12'd0, 5'd2, 5'd1, 3'b010));
    run_program();
    repeat (20) begin
      @(negedge clock);
      check_halt("halted", halted, 1'b1);
    end
    check_stores();
  endtask

  initial begin
    reset = 1'b1;
    void'($urandom(32'h353431cc));
    mem0.fill();
    alu_results();
    upper_immediates();
    branch_paths();
    jump_links();
    load_store_lanes();
    illegal_opcode_halt();
    $display("All tests passed!");
    $finish;
  end

endmodule

//--- sources.f
hw/rv_pkg.sv
hw/alu.sv
hw/register_file.sv
hw/imm_gen.sv
hw/datapath.sv
hw/control_unit.sv
hw/rv32_multicycle.sv
verif/tb_memory.sv
verif/tb_rv32.sv

//--- Bender.yml
package:
  name: rv32_multicycle

sources:
  - files:
      - hw/rv_pkg.sv
      - hw/alu.sv
      - hw/register_file.sv
      - hw/imm_gen.sv
      - hw/datapath.sv
      - hw/control_unit.sv
      - hw/rv32_multicycle.sv
  - target: test
    files:
      - verif/tb_memory.sv
      - verif/tb_rv32.sv
